//--- compile.f
common/difflogic_pkg.sv
logic/credit_fifo.sv
logic/difflogic_layer.sv
groupsum/fixed_difflogic_groupsum.sv
groupsum/class_argmax.sv
logic/difflogic_net_top.sv
dv/difflogic_net_tb.sv

//--- dv/difflogic_net_tb.sv
`timescale 1ns/1ps

module difflogic_net_tb
  import difflogic_pkg::*;
();

  localparam int RES_W = CLASS_W + SCORE_W;

  logic               clk;
  logic               reset;
  logic               in_valid;
  logic [IN_BITS-1:0] in_data;
  logic               in_credit;
  logic               out_valid;
  logic [CLASS_W-1:0] out_class;
  logic [SCORE_W-1:0] out_score;
  logic               out_credit;

  // source, sink and scoreboard state
  logic [31:0]        rng_state;
  logic [RES_W-1:0]   exp_q[$];
  logic [IN_BITS-1:0] tie_vecs[$];
  string              test_name;
  int                 src_credit;
  int                 sent;
  int                 received;
  int                 credit_pulses;
  int                 sink_held;
  // 0 returns credit at once, 1 after a random delay
  int                 sink_mode;

  difflogic_net_top dut_i (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_class  (out_class),
    .out_score  (out_score),
    .out_credit (out_credit)
  );

  always #4 clk = ~clk;

  // 32-bit xorshift
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // both gate layers, then the popcount of each class group
  function automatic logic [NUM_CLASSES-1:0][SCORE_W-1:0] model_scores(
    input logic [IN_BITS-1:0] vec
  );
    logic [LAYER_WIDTH-1:0]              cur;
    logic [LAYER_WIDTH-1:0]              nxt;
    logic [NUM_CLASSES-1:0][SCORE_W-1:0] scores;
    int                                  ones;
    cur = LAYER_WIDTH'(vec);
    for (int l = 0; l < NUM_LAYERS; l++) begin
      for (int g = 0; g < LAYER_WIDTH; g++) begin
        nxt[g] = apply_gate(LAYER_OP[l][g], cur[LAYER_SRC_A[l][g]], cur[LAYER_SRC_B[l][g]]);
      end
      cur = nxt;
    end
    for (int c = 0; c < NUM_CLASSES; c++) begin
      ones = 0;
      for (int k = 0; k < GROUP_SIZE; k++) begin
        ones += cur[c * GROUP_SIZE + k];
      end
      scores[c] = SCORE_W'(ones);
    end
    return scores;
  endfunction

  // expected {class, score}, first maximum wins
  function automatic logic [RES_W-1:0] model_result(input logic [IN_BITS-1:0] vec);
    logic [NUM_CLASSES-1:0][SCORE_W-1:0] scores;
    int                                  best_c;
    logic [SCORE_W-1:0]                  best_s;
    scores = model_scores(vec);
    best_c = 0;
    best_s = scores[0];
    for (int c = 1; c < NUM_CLASSES; c++) begin
      if (scores[c] > best_s) begin
        best_c = c;
        best_s = scores[c];
      end
    end
    return {CLASS_W'(best_c), best_s};
  endfunction

  // true when the top score shows up in more than one class
  function automatic logic top_tied(input logic [NUM_CLASSES-1:0][SCORE_W-1:0] scores);
    logic [SCORE_W-1:0] top;
    int                 hits;
    top = '0;
    hits = 0;
    for (int c = 0; c < NUM_CLASSES; c++) begin
      if (scores[c] > top) top = scores[c];
    end
    for (int c = 0; c < NUM_CLASSES; c++) begin
      if (scores[c] == top) hits++;
    end
    return hits > 1;
  endfunction

  task automatic fail_run(input string msg);
    $display("ERROR: %s", msg);
    $display("sim failed");
    $fatal(1, "testbench stopped");
  endtask

  task automatic check_equal(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
      $display("sim failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // outputs are stable at the falling edge
  task automatic observe();
    logic [RES_W-1:0] expected;
    if (in_credit) begin
      credit_pulses++;
      src_credit++;
      check_equal({test_name, " source credit bound"}, 1, src_credit <= CREDIT_DEPTH);
    end
    if (out_valid) begin
      if (exp_q.size() == 0) begin
        fail_run($sformatf("%s: output seen with no input outstanding", test_name));
      end else begin
        expected = exp_q.pop_front();
        check_equal({test_name, " result"}, expected, {out_class, out_score});
        received++;
        sink_held++;
        check_equal({test_name, " sink outstanding bound"}, 1, sink_held <= CREDIT_DEPTH);
      end
    end
  endtask

  // one cycle: observe, then drive source and sink
  task automatic tick(input logic want, input logic [IN_BITS-1:0] vec, output logic taken);
    logic [31:0] r;
    @(negedge clk);
    observe();
    // source only sends on a held credit
    taken = want && (src_credit > 0);
    in_valid = taken;
    in_data = vec;
    if (taken) begin
      src_credit--;
      sent++;
      exp_q.push_back(model_result(vec));
    end
    out_credit = 1'b0;
    r = next_rand();
    if (sink_held > 0 && (sink_mode == 0 || r[3:2] == 2'b00)) begin
      out_credit = 1'b1;
      sink_held--;
    end
  endtask

  task automatic send_vector(input logic [IN_BITS-1:0] vec);
    logic taken;
    int   waited;
    taken = 1'b0;
    waited = 0;
    while (!taken) begin
      tick(1'b1, vec, taken);
      waited++;
      if (!taken && waited > 200) begin
        fail_run($sformatf("%s: source got no in_credit for 200 cycles", test_name));
      end
    end
  endtask

  task automatic send_random(input int count, input logic gaps);
    logic        taken;
    logic        want;
    logic [31:0] r;
    int          done;
    int          waited;
    done = 0;
    waited = 0;
    while (done < count) begin
      r = next_rand();
      // with gaps, skip about one cycle in four
      want = !gaps || (r[17:16] != 2'b00);
      tick(want, r[IN_BITS-1:0], taken);
      if (taken) begin
        done++;
        waited = 0;
      end else begin
        waited++;
        if (waited > 200) begin
          fail_run($sformatf("%s: source stalled for 200 cycles", test_name));
        end
      end
    end
  endtask

  // idle until every result is out and every sink credit returned
  task automatic drain();
    logic taken;
    int   waited;
    waited = 0;
    while (exp_q.size() != 0 || sink_held != 0) begin
      tick(1'b0, '0, taken);
      waited++;
      if (waited > 2000) begin
        fail_run($sformatf("%s: pipeline did not drain in 2000 cycles", test_name));
      end
    end
  endtask

  initial begin
    logic                                taken;
    logic [31:0]                         r;
    logic [IN_BITS-1:0]                  vec;
    logic [NUM_CLASSES-1:0][SCORE_W-1:0] scores;
    int                                  lat;
    clk = 1'b0;
    reset = 1'b1;
    in_valid = 1'b0;
    in_data = '0;
    out_credit = 1'b0;
    rng_state = 32'd85810;
    src_credit = CREDIT_DEPTH;
    sent = 0;
    received = 0;
    credit_pulses = 0;
    sink_held = 0;
    sink_mode = 0;
    test_name = "reset";
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // idle pipeline stays quiet
    test_name = "reset_quiet";
    for (int i = 0; i < 10; i++) begin
      tick(1'b0, '0, taken);
      check_equal("reset_quiet out_valid", 0, out_valid);
      check_equal("reset_quiet in_credit", 0, in_credit);
    end

    // single vector, four stages of two cycles
    test_name = "single_latency";
    r = next_rand();
    send_vector(r[IN_BITS-1:0]);
    lat = 0;
    do begin
      tick(1'b0, '0, taken);
      lat++;
      if (lat > 30) begin
        fail_run("single_latency: no output within 30 cycles");
      end
    end while (!out_valid);
    check_equal("single_latency cycles", 8, lat);
    drain();

    test_name = "all_zeros";
    send_vector('0);
    drain();
    test_name = "all_ones";
    send_vector('1);
    drain();

    // odd stride walks the whole input space
    for (int i = 0; i < 65536 && tie_vecs.size() < 4; i++) begin
      vec = IN_BITS'(i * 40503);
      scores = model_scores(vec);
      if (top_tied(scores)) tie_vecs.push_back(vec);
    end
    if (tie_vecs.size() == 0) begin
      fail_run("tied_scores: no input vector gives tied class scores");
    end
    test_name = "tied_scores";
    foreach (tie_vecs[j]) begin
      send_vector(tie_vecs[j]);
    end
    drain();

    // full rate, sink pays back at once
    test_name = "random_stream";
    sink_mode = 0;
    send_random(200, 1'b0);
    drain();

    // random gaps and random sink delay
    test_name = "random_backpressure";
    sink_mode = 1;
    send_random(200, 1'b1);
    drain();

    test_name = "credit_totals";
    check_equal("credit_totals in_credit pulses", sent, credit_pulses);

    $display("sim passed");
    $finish;
  end

endmodule

//--- logic/difflogic_net_top.sv
`timescale 1ns/1ps

module difflogic_net_top
  import difflogic_pkg::*;
(
  input  logic               clk,
  input  logic               reset,
  input  logic               in_valid,
  input  logic [IN_BITS-1:0] in_data,
  output logic               in_credit,
  output logic               out_valid,
  output logic [CLASS_W-1:0] out_class,
  output logic [SCORE_W-1:0] out_score,
  input  logic               out_credit
);

  // layer 0 to layer 1
  logic                                l0_valid;
  logic [LAYER_WIDTH-1:0]              l0_data;
  logic                                l0_credit;
  // layer 1 to groupsum
  logic                                l1_valid;
  logic [LAYER_WIDTH-1:0]              l1_data;
  logic                                l1_credit;
  // groupsum to argmax
  logic                                gs_valid;
  logic [NUM_CLASSES-1:0][SCORE_W-1:0] gs_scores;
  logic                                gs_credit;

  difflogic_layer #(
    .LAYER(0)
  ) u_layer0 (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .in_credit  (in_credit),
    .out_valid  (l0_valid),
    .out_data   (l0_data),
    .out_credit (l0_credit)
  );

  difflogic_layer #(
    .LAYER(1)
  ) u_layer1 (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (l0_valid),
    .in_data    (l0_data),
    .in_credit  (l0_credit),
    .out_valid  (l1_valid),
    .out_data   (l1_data),
    .out_credit (l1_credit)
  );

  fixed_difflogic_groupsum u_groupsum (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (l1_valid),
    .in_data    (l1_data),
    .in_credit  (l1_credit),
    .out_valid  (gs_valid),
    .out_scores (gs_scores),
    .out_credit (gs_credit)
  );

  class_argmax u_argmax (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (gs_valid),
    .in_scores  (gs_scores),
    .in_credit  (gs_credit),
    .out_valid  (out_valid),
    .out_class  (out_class),
    .out_score  (out_score),
    .out_credit (out_credit)
  );

endmodule

//--- groupsum/class_argmax.sv
`timescale 1ns/1ps

module class_argmax
  import difflogic_pkg::*;
(
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                in_valid,
  input  logic [NUM_CLASSES-1:0][SCORE_W-1:0] in_scores,
  output logic                                in_credit,
  output logic                                out_valid,
  output logic [CLASS_W-1:0]                  out_class,
  output logic [SCORE_W-1:0]                  out_score,
  input  logic                                out_credit
);

  logic                                head_valid;
  logic [NUM_CLASSES-1:0][SCORE_W-1:0] head_scores;
  logic                                pop;
  logic [CREDIT_W-1:0]                 credit_cnt;
  logic [CLASS_W-1:0]                  best_class;
  logic [SCORE_W-1:0]                  best_score;

  credit_fifo #(
    .WIDTH(NUM_CLASSES * SCORE_W)
  ) u_fifo (
    .clk      (clk),
    .reset    (reset),
    .wr_valid (in_valid),
    .wr_data  (in_scores),
    .rd_valid (head_valid),
    .rd_data  (head_scores),
    .rd_pop   (pop),
    .credit   (in_credit)
  );

  // strict compare, so a tie keeps the lower index
  always_comb begin
    best_class = '0;
    best_score = head_scores[0];
    for (int i = 1; i < NUM_CLASSES; i++) begin
      if (head_scores[i] > best_score) begin
        best_class = CLASS_W'(i);
        best_score = head_scores[i];
      end
    end
  end

  assign pop = head_valid && (credit_cnt > CREDIT_W'(out_valid));

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid  <= 1'b0;
      credit_cnt <= CREDIT_W'(CREDIT_DEPTH);
    end else begin
      out_valid  <= pop;
      // sink credits come straight from the top port
      credit_cnt <= credit_cnt - CREDIT_W'(out_valid) + CREDIT_W'(out_credit);
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      out_class <= best_class;
      out_score <= best_score;
    end
  end

  // each output item is backed by a sink credit
  a_valid_has_credit: assert property (@(posedge clk) disable iff (reset)
    out_valid |-> credit_cnt != '0);

endmodule

//--- groupsum/fixed_difflogic_groupsum.sv
`timescale 1ns/1ps

module fixed_difflogic_groupsum
  import difflogic_pkg::*;
(
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                in_valid,
  input  logic [LAYER_WIDTH-1:0]              in_data,
  output logic                                in_credit,
  output logic                                out_valid,
  output logic [NUM_CLASSES-1:0][SCORE_W-1:0] out_scores,
  input  logic                                out_credit
);

  logic                                head_valid;
  logic [LAYER_WIDTH-1:0]              head_data;
  logic                                pop;
  logic [CREDIT_W-1:0]                 credit_cnt;
  logic [NUM_CLASSES-1:0][SCORE_W-1:0] group_sum;

  credit_fifo #(
    .WIDTH(LAYER_WIDTH)
  ) u_fifo (
    .clk      (clk),
    .reset    (reset),
    .wr_valid (in_valid),
    .wr_data  (in_data),
    .rd_valid (head_valid),
    .rd_data  (head_data),
    .rd_pop   (pop),
    .credit   (in_credit)
  );

  // class i counts the ones in bits i*GROUP_SIZE upward
  for (genvar i = 0; i < NUM_CLASSES; i++) begin : gen_group
    assign group_sum[i] = SCORE_W'($countones(head_data[i*GROUP_SIZE +: GROUP_SIZE]));
  end

  // hold back while the last valid is still unpaid
  assign pop = head_valid && (credit_cnt > CREDIT_W'(out_valid));

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid  <= 1'b0;
      credit_cnt <= CREDIT_W'(CREDIT_DEPTH);
    end else begin
      out_valid  <= pop;
      credit_cnt <= credit_cnt - CREDIT_W'(out_valid) + CREDIT_W'(out_credit);
    end
  end

  // registered scores
  always_ff @(posedge clk) begin
    if (pop) begin
      out_scores <= group_sum;
    end
  end

endmodule

//--- logic/difflogic_layer.sv
`timescale 1ns/1ps

module difflogic_layer
  import difflogic_pkg::*;
#(
  parameter int LAYER = 0
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   in_valid,
  input  logic [LAYER_WIDTH-1:0] in_data,
  output logic                   in_credit,
  output logic                   out_valid,
  output logic [LAYER_WIDTH-1:0] out_data,
  input  logic                   out_credit
);

  logic                   head_valid;
  logic [LAYER_WIDTH-1:0] head_data;
  logic                   pop;
  logic [CREDIT_W-1:0]    credit_cnt;
  logic [LAYER_WIDTH-1:0] gate_out;

  // receive buffer, owns the upstream credits
  credit_fifo #(
    .WIDTH(LAYER_WIDTH)
  ) u_fifo (
    .clk      (clk),
    .reset    (reset),
    .wr_valid (in_valid),
    .wr_data  (in_data),
    .rd_valid (head_valid),
    .rd_data  (head_data),
    .rd_pop   (pop),
    .credit   (in_credit)
  );

  // evaluate every gate on the fifo head
  for (genvar g = 0; g < LAYER_WIDTH; g++) begin : gen_gate
    assign gate_out[g] = apply_gate(LAYER_OP[LAYER][g],
                                    head_data[LAYER_SRC_A[LAYER][g]],
                                    head_data[LAYER_SRC_B[LAYER][g]]);
  end

  // the valid already on the wire still holds one credit
  assign pop = head_valid && (credit_cnt > CREDIT_W'(out_valid));

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid  <= 1'b0;
      credit_cnt <= CREDIT_W'(CREDIT_DEPTH);
    end else begin
      out_valid  <= pop;
      // a valid spends one, a returned pulse gives one back
      credit_cnt <= credit_cnt - CREDIT_W'(out_valid) + CREDIT_W'(out_credit);
    end
  end

  // result register
  always_ff @(posedge clk) begin
    if (pop) begin
      out_data <= gate_out;
    end
  end

  // downstream never returns more than it was given
  a_credit_bound: assert property (@(posedge clk) disable iff (reset)
    credit_cnt <= CREDIT_W'(CREDIT_DEPTH));

endmodule

//--- logic/credit_fifo.sv
`timescale 1ns/1ps

module credit_fifo
  import difflogic_pkg::*;
#(
  parameter int WIDTH = 16
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             wr_valid,
  input  logic [WIDTH-1:0] wr_data,
  output logic             rd_valid,
  output logic [WIDTH-1:0] rd_data,
  input  logic             rd_pop,
  output logic             credit
);

  localparam int PTR_W = (CREDIT_DEPTH > 1) ? $clog2(CREDIT_DEPTH) : 1;

  logic [WIDTH-1:0]    mem [CREDIT_DEPTH];
  logic [PTR_W-1:0]    wr_ptr;
  logic [PTR_W-1:0]    rd_ptr;
  logic [CREDIT_W-1:0] count;

  // head is shown as soon as anything is stored
  assign rd_valid = (count != '0);
  assign rd_data  = mem[rd_ptr];

  // payload storage
  always_ff @(posedge clk) begin
    if (wr_valid) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      if (wr_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(CREDIT_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(CREDIT_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count  <= count + CREDIT_W'(wr_valid) - CREDIT_W'(rd_pop);
      // one credit back to the sender per freed slot
      credit <= rd_pop;
    end
  end

  // sender overran its credits
  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    !(wr_valid && count == CREDIT_W'(CREDIT_DEPTH)));

  // consumer popped a missing entry
  a_no_underflow: assert property (@(posedge clk) disable iff (reset)
    rd_pop |-> rd_valid);

endmodule

//--- common/difflogic_pkg.sv
package difflogic_pkg;

  // datapath widths
  localparam int IN_BITS     = 16;
  localparam int LAYER_WIDTH = 16;
  localparam int NUM_LAYERS  = 2;
  localparam int NUM_CLASSES = 4;
  localparam int GROUP_SIZE  = LAYER_WIDTH / NUM_CLASSES;
  // score must hold a full group of ones
  localparam int SCORE_W     = $clog2(GROUP_SIZE + 1);
  localparam int CLASS_W     = $clog2(NUM_CLASSES);

  // receiver buffer entries, also the sender's starting credit
  localparam int CREDIT_DEPTH = 2;
  localparam int CREDIT_W     = $clog2(CREDIT_DEPTH + 1);

  // truth table code, bit {a,b} holds the gate output
  typedef logic [3:0] gate_op_t;

  localparam gate_op_t OP_FALSE   = 4'b0000;
  localparam gate_op_t OP_NOR     = 4'b0001;
  localparam gate_op_t OP_NA_B    = 4'b0010;
  localparam gate_op_t OP_NOT_A   = 4'b0011;
  localparam gate_op_t OP_A_NB    = 4'b0100;
  localparam gate_op_t OP_NOT_B   = 4'b0101;
  localparam gate_op_t OP_XOR     = 4'b0110;
  localparam gate_op_t OP_NAND    = 4'b0111;
  localparam gate_op_t OP_AND     = 4'b1000;
  localparam gate_op_t OP_XNOR    = 4'b1001;
  localparam gate_op_t OP_B       = 4'b1010;
  localparam gate_op_t OP_NA_OR_B = 4'b1011;
  localparam gate_op_t OP_A       = 4'b1100;
  localparam gate_op_t OP_A_OR_NB = 4'b1101;
  localparam gate_op_t OP_OR      = 4'b1110;
  localparam gate_op_t OP_TRUE    = 4'b1111;

  // trained wiring, input bit feeding side a of each gate
  localparam logic [3:0] LAYER_SRC_A [NUM_LAYERS][LAYER_WIDTH] = '{
    '{4'd0, 4'd2, 4'd4, 4'd6, 4'd8, 4'd10, 4'd12, 4'd14,
      4'd1, 4'd3, 4'd5, 4'd7, 4'd9, 4'd11, 4'd13, 4'd15},
    '{4'd3, 4'd7, 4'd11, 4'd15, 4'd0, 4'd4, 4'd8, 4'd12,
      4'd1, 4'd5, 4'd9, 4'd13, 4'd2, 4'd6, 4'd10, 4'd14}
  };

  // side b of each gate
  localparam logic [3:0] LAYER_SRC_B [NUM_LAYERS][LAYER_WIDTH] = '{
    '{4'd1, 4'd3, 4'd5, 4'd7, 4'd9, 4'd11, 4'd13, 4'd15,
      4'd4, 4'd8, 4'd12, 4'd0, 4'd6, 4'd10, 4'd14, 4'd2},
    '{4'd8, 4'd1, 4'd6, 4'd2, 4'd12, 4'd9, 4'd5, 4'd0,
      4'd14, 4'd10, 4'd3, 4'd7, 4'd11, 4'd15, 4'd4, 4'd13}
  };

  // trained gate choice per layer and gate
  localparam gate_op_t LAYER_OP [NUM_LAYERS][LAYER_WIDTH] = '{
    '{OP_AND, OP_OR, OP_XOR, OP_NAND, OP_A, OP_NOR, OP_XNOR, OP_B,
      OP_A_NB, OP_NA_B, OP_OR, OP_AND, OP_NOT_A, OP_A_OR_NB, OP_XOR, OP_NA_OR_B},
    '{OP_OR, OP_AND, OP_B, OP_XOR, OP_NOT_B, OP_A, OP_NAND, OP_TRUE,
      OP_AND, OP_FALSE, OP_OR, OP_XNOR, OP_A_NB, OP_NOR, OP_NA_B, OP_OR}
  };

  // one gate, shared by the RTL and the model
  function automatic logic apply_gate(input gate_op_t op, input logic a, input logic b);
    return op[{a, b}];
  endfunction

endpackage
